/* design/cps_video_pkg.sv */
/*
 * Shared widths, types, screen timing constants and register map
 * for the CPS-1 style pixel back end
 */
`default_nettype none

package cps_video_pkg;

    // Screen position counters
    typedef logic [8:0] hcount_t;
    typedef logic [8:0] vcount_t;

    // Palette row in 8..4, colour in 3..0
    typedef logic [8:0]  layer_pxl_t;
    // Layer id, palette row, colour
    typedef logic [10:0] pal_index_t;
    // Brightness, red, green, blue nibbles
    typedef logic [15:0] pal_entry_t;
    typedef logic [7:0]  colour_t;

    typedef logic [15:0] cpu_data_t;
    typedef logic [4:0]  cpu_addr_t;

    typedef enum logic [1:0] {
        layer_obj  = 2'd0,
        layer_scr1 = 2'd1,
        layer_scr2 = 2'd2,
        layer_scr3 = 2'd3
    } layer_id_t;

    // Horizontal timing in pixels
    localparam int h_total      = 512;
    localparam int h_active     = 384;
    localparam int h_sync_start = 424;
    localparam int h_sync_end   = 456;

    // Vertical timing in lines
    localparam int v_total      = 262;
    localparam int v_active     = 224;
    localparam int v_sync_start = 236;
    localparam int v_sync_end   = 239;

    // Pixel enables from layer pixels to colour outputs
    localparam int pixel_latency = 3;

    // Word addresses of the CPU registers
    localparam cpu_addr_t reg_layer_ctrl = 5'd0;
    localparam cpu_addr_t reg_raster     = 5'd1;

    // Order obj, scr1, scr2, scr3 from the top, all layers on
    localparam cpu_data_t layer_ctrl_reset = 16'h0fe4;

    localparam logic [3:0] transparent_colour = 4'd15;
    localparam pal_index_t backdrop_index     = '1;

endpackage

`default_nettype wire

/* design/video_timing.sv */
/*
 * Screen timing generator: pixel and line counters, sync and
 * blanking levels, line and frame start strobes
 */
`default_nettype none

module video_timing (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   pxl_cen,
    output cps_video_pkg::hcount_t hdump,
    output cps_video_pkg::vcount_t vdump,
    output logic                   hs,
    output logic                   vs,
    output logic                   hb,
    output logic                   vb,
    output logic                   line_start,
    output logic                   frame_start
);
    import cps_video_pkg::*;

    hcount_t h_next;
    vcount_t v_next;
    logic    h_last;
    logic    v_last;

    assign h_last = hdump == hcount_t'(h_total - 1);
    assign v_last = vdump == vcount_t'(v_total - 1);

    // Line counter moves only when the pixel counter wraps
    assign h_next = h_last ? '0 : hdump + 1'b1;
    assign v_next = !h_last ? vdump :
                    v_last  ? '0    : vdump + 1'b1;

    // Levels decode the next count so they line up with hdump and vdump
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hdump       <= '0;
            vdump       <= '0;
            hs          <= 1'b0;
            vs          <= 1'b0;
            hb          <= 1'b0;
            vb          <= 1'b0;
            line_start  <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            line_start  <= 1'b0;
            frame_start <= 1'b0;
            if (pxl_cen) begin
                hdump <= h_next;
                vdump <= v_next;
                hb    <= h_next >= h_active;
                vb    <= v_next >= v_active;
                hs    <= h_next >= h_sync_start && h_next < h_sync_end;
                vs    <= v_next >= v_sync_start && v_next < v_sync_end;
                // Strobes last one clock, not one pixel
                line_start  <= h_last;
                frame_start <= h_last && v_last;
            end
        end
    end

endmodule

`default_nettype wire

/* design/video_regs.sv */
/*
 * CPU register block: layer control and raster line registers with
 * byte-masked writes, readback and the raster interrupt pulse
 */
`default_nettype none

module video_regs (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     ppu_cs,
    input  cps_video_pkg::cpu_addr_t addr,
    input  logic [1:0]               dsn,
    input  cps_video_pkg::cpu_data_t cpu_dout,
    input  cps_video_pkg::vcount_t   vdump,
    input  logic                     line_start,
    output cps_video_pkg::cpu_data_t mmr_dout,
    output cps_video_pkg::cpu_data_t layer_ctrl,
    output logic                     raster
);
    import cps_video_pkg::*;

    cpu_data_t raster_reg;
    logic      raster_en;
    vcount_t   raster_line;

    // dsn[1] low selects the upper byte, dsn[0] low the lower one
    function automatic cpu_data_t byte_merge(
        input cpu_data_t  old_val,
        input cpu_data_t  new_val,
        input logic [1:0] sel_n
    );
        cpu_data_t merged;
        merged = old_val;
        if (!sel_n[1]) begin
            merged[15:8] = new_val[15:8];
        end
        if (!sel_n[0]) begin
            merged[7:0] = new_val[7:0];
        end
        return merged;
    endfunction

    assign raster_en   = raster_reg[15];
    assign raster_line = raster_reg[8:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            layer_ctrl <= layer_ctrl_reset;
            raster_reg <= '0;
        end else if (ppu_cs) begin
            if (addr == reg_layer_ctrl) begin
                layer_ctrl <= byte_merge(layer_ctrl, cpu_dout, dsn);
            end
            if (addr == reg_raster) begin
                raster_reg <= byte_merge(raster_reg, cpu_dout, dsn);
            end
        end
    end

    // vdump already holds the new line while line_start is high
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            raster <= 1'b0;
        end else begin
            raster <= line_start && raster_en && vdump == raster_line;
        end
    end

    always_comb begin
        case (addr)
            reg_layer_ctrl: mmr_dout = layer_ctrl;
            reg_raster:     mmr_dout = raster_reg;
            default:        mmr_dout = '0;
        endcase
    end

endmodule

`default_nettype wire

/* design/layer_mixer.sv */
/*
 * Layer priority mixer with colour 15 transparency
 */
`default_nettype none

module layer_mixer (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      pxl_cen,
    input  cps_video_pkg::cpu_data_t  layer_ctrl,
    input  cps_video_pkg::layer_pxl_t obj_pxl,
    input  cps_video_pkg::layer_pxl_t scr1_pxl,
    input  cps_video_pkg::layer_pxl_t scr2_pxl,
    input  cps_video_pkg::layer_pxl_t scr3_pxl,
    output cps_video_pkg::pal_index_t pal_index
);
    import cps_video_pkg::*;

    layer_pxl_t pxl_by_id [4];
    logic [3:0] layer_en;
    pal_index_t next_index;

    assign pxl_by_id[layer_obj]  = obj_pxl;
    assign pxl_by_id[layer_scr1] = scr1_pxl;
    assign pxl_by_id[layer_scr2] = scr2_pxl;
    assign pxl_by_id[layer_scr3] = scr3_pxl;

    // Enables are indexed by layer id, not by slot
    assign layer_en = layer_ctrl[11:8];

    // Bottom slot first, so a higher slot overrides it
    always_comb begin
        layer_id_t  slot_id;
        layer_pxl_t slot_pxl;
        next_index = backdrop_index;
        for (int slot = 3; slot >= 0; slot--) begin
            slot_id  = layer_id_t'(layer_ctrl[2*slot +: 2]);
            slot_pxl = pxl_by_id[slot_id];
            if (layer_en[slot_id] && slot_pxl[3:0] != transparent_colour) begin
                next_index = {slot_id, slot_pxl};
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pal_index <= backdrop_index;
        end else if (pxl_cen) begin
            pal_index <= next_index;
        end
    end

endmodule

`default_nettype wire

/* design/palette_lut.sv */
/*
 * Palette RAM with CPU write port, brightness colour conversion
 * and the matching blanking delay line
 */
`default_nettype none

module palette_lut (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      pxl_cen,
    input  cps_video_pkg::pal_index_t pal_index,
    input  logic                      hb,
    input  logic                      vb,
    input  logic                      pal_we,
    input  cps_video_pkg::pal_index_t pal_waddr,
    input  cps_video_pkg::pal_entry_t pal_wdata,
    output cps_video_pkg::colour_t    red,
    output cps_video_pkg::colour_t    green,
    output cps_video_pkg::colour_t    blue,
    output logic                      lhbl_dly,
    output logic                      lvbl_dly
);
    import cps_video_pkg::*;

    pal_entry_t                pal_ram [2048];
    pal_entry_t                rd_entry;
    logic [pixel_latency-1:0]  hb_dly;
    logic [pixel_latency-1:0]  vb_dly;
    logic                      blank_next;

    // nibble * (16 + brightness) / 2
    function automatic colour_t conv(input logic [3:0] nib, input logic [3:0] bright);
        logic [8:0] prod;
        prod = {5'd0, nib} * {4'd0, 1'b1, bright};
        return prod[8:1];
    endfunction

    always_ff @(posedge clk) begin
        if (pal_we) begin
            pal_ram[pal_waddr] <= pal_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            rd_entry <= pal_ram[pal_index];
        end
    end

    // Blank stage that lands on the outputs with the colour
    assign blank_next = hb_dly[pixel_latency-2] || vb_dly[pixel_latency-2];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hb_dly <= '0;
            vb_dly <= '0;
            red    <= '0;
            green  <= '0;
            blue   <= '0;
        end else if (pxl_cen) begin
            hb_dly <= {hb_dly[pixel_latency-2:0], hb};
            vb_dly <= {vb_dly[pixel_latency-2:0], vb};
            red    <= blank_next ? '0 : conv(rd_entry[11:8], rd_entry[15:12]);
            green  <= blank_next ? '0 : conv(rd_entry[7:4], rd_entry[15:12]);
            blue   <= blank_next ? '0 : conv(rd_entry[3:0], rd_entry[15:12]);
        end
    end

    assign lhbl_dly = ~hb_dly[pixel_latency-1];
    assign lvbl_dly = ~vb_dly[pixel_latency-1];

endmodule

`default_nettype wire

/* design/cps_video.sv */
/*
 * Pixel back end top: timing, CPU registers, layer mixer and palette
 */
`default_nettype none

module cps_video (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      pxl_cen,
    // CPU side
    input  logic                      ppu_cs,
    input  cps_video_pkg::cpu_addr_t  addr,
    input  logic [1:0]                dsn,
    input  cps_video_pkg::cpu_data_t  cpu_dout,
    output cps_video_pkg::cpu_data_t  mmr_dout,
    output logic                      raster,
    // Layer pixels
    input  cps_video_pkg::layer_pxl_t obj_pxl,
    input  cps_video_pkg::layer_pxl_t scr1_pxl,
    input  cps_video_pkg::layer_pxl_t scr2_pxl,
    input  cps_video_pkg::layer_pxl_t scr3_pxl,
    // Palette load
    input  logic                      pal_we,
    input  cps_video_pkg::pal_index_t pal_waddr,
    input  cps_video_pkg::pal_entry_t pal_wdata,
    // Video out
    output cps_video_pkg::hcount_t    hdump,
    output cps_video_pkg::vcount_t    vdump,
    output logic                      hs,
    output logic                      vs,
    output logic                      hb,
    output logic                      vb,
    output cps_video_pkg::colour_t    red,
    output cps_video_pkg::colour_t    green,
    output cps_video_pkg::colour_t    blue,
    output logic                      lhbl_dly,
    output logic                      lvbl_dly
);
    import cps_video_pkg::*;

    logic       line_start;
    cpu_data_t  layer_ctrl;
    pal_index_t pal_index;

    video_timing u_timing (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .pxl_cen     ( pxl_cen     ),
        .hdump       ( hdump       ),
        .vdump       ( vdump       ),
        .hs          ( hs          ),
        .vs          ( vs          ),
        .hb          ( hb          ),
        .vb          ( vb          ),
        .line_start  ( line_start  ),
        .frame_start (             )
    );

    video_regs u_regs (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .ppu_cs      ( ppu_cs      ),
        .addr        ( addr        ),
        .dsn         ( dsn         ),
        .cpu_dout    ( cpu_dout    ),
        .vdump       ( vdump       ),
        .line_start  ( line_start  ),
        .mmr_dout    ( mmr_dout    ),
        .layer_ctrl  ( layer_ctrl  ),
        .raster      ( raster      )
    );

    layer_mixer u_mixer (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .pxl_cen     ( pxl_cen     ),
        .layer_ctrl  ( layer_ctrl  ),
        .obj_pxl     ( obj_pxl     ),
        .scr1_pxl    ( scr1_pxl    ),
        .scr2_pxl    ( scr2_pxl    ),
        .scr3_pxl    ( scr3_pxl    ),
        .pal_index   ( pal_index   )
    );

    palette_lut u_pal (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .pxl_cen     ( pxl_cen     ),
        .pal_index   ( pal_index   ),
        .hb          ( hb          ),
        .vb          ( vb          ),
        .pal_we      ( pal_we      ),
        .pal_waddr   ( pal_waddr   ),
        .pal_wdata   ( pal_wdata   ),
        .red         ( red         ),
        .green       ( green       ),
        .blue        ( blue        ),
        .lhbl_dly    ( lhbl_dly    ),
        .lvbl_dly    ( lvbl_dly    )
    );

endmodule

`default_nettype wire

/* tests/tb_cps_video.sv */
/*
 * Directed testbench for the cps_video pixel back end: register
 * readback, screen timing, palette colours, priority, blanking, raster
 */
`default_nettype none

module tb_cps_video;
    timeunit 1ns;
    timeprecision 1ns;

    import cps_video_pkg::*;

    localparam int frame_pixels = h_total * v_total;
    localparam int frame_clks   = 2 * frame_pixels;
    // Frame start wait, timing frame, blanking frame, two raster frames, short tests
    localparam int timeout_clks = 6 * frame_clks;

    logic       clk;
    logic       rst;
    logic       pxl_cen;
    logic       ppu_cs;
    cpu_addr_t  addr;
    logic [1:0] dsn;
    cpu_data_t  cpu_dout;
    cpu_data_t  mmr_dout;
    logic       raster;
    layer_pxl_t obj_pxl;
    layer_pxl_t scr1_pxl;
    layer_pxl_t scr2_pxl;
    layer_pxl_t scr3_pxl;
    logic       pal_we;
    pal_index_t pal_waddr;
    pal_entry_t pal_wdata;
    hcount_t    hdump;
    vcount_t    vdump;
    logic       hs;
    logic       vs;
    logic       hb;
    logic       vb;
    colour_t    red;
    colour_t    green;
    colour_t    blue;
    logic       lhbl_dly;
    logic       lvbl_dly;

    logic [31:0] lfsr_state;
    int          cycles = 0;
    // Known pixels per layer id and their palette entries, backdrop last
    layer_pxl_t  prio_pxl [4];
    pal_entry_t  layer_entry [5];

    cps_video uut (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // One pixel every second clock
    always @(posedge clk) begin
        pxl_cen <= ~pxl_cen;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_clks) begin
            stop_run($sformatf("timeout: tests still running after %0d clocks", cycles));
        end
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_cpu_data(input string name, input cpu_data_t exp, input cpu_data_t act);
        if (act !== exp) begin
            stop_run($sformatf("error: %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_colour(input string name, input colour_t exp, input colour_t act);
        if (act !== exp) begin
            stop_run($sformatf("error: %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input vcount_t exp, input vcount_t act);
        if (act !== exp) begin
            stop_run($sformatf("error: %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_run($sformatf("error: %s expected %b actual %b", name, exp, act));
        end
    endtask

    // Galois form, taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? (s >> 1) ^ 32'h8020_0003 : s >> 1;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    // Channel = nibble * (16 + brightness) / 2
    function automatic colour_t expected_channel(input logic [3:0] nib, input logic [3:0] bright);
        int scaled;
        scaled = int'(nib) * (16 + int'(bright));
        return colour_t'(scaled / 2);
    endfunction

    task automatic cpu_write(input cpu_addr_t a, input logic [1:0] sel_n, input cpu_data_t d);
        @(posedge clk);
        ppu_cs   <= 1'b1;
        addr     <= a;
        dsn      <= sel_n;
        cpu_dout <= d;
        @(posedge clk);
        ppu_cs <= 1'b0;
        dsn    <= 2'b11;
    endtask

    task automatic cpu_read(input cpu_addr_t a, output cpu_data_t d);
        @(posedge clk);
        addr <= a;
        @(negedge clk);
        d = mmr_dout;
    endtask

    task automatic pal_write(input pal_index_t a, input pal_entry_t d);
        @(posedge clk);
        pal_we    <= 1'b1;
        pal_waddr <= a;
        pal_wdata <= d;
        @(posedge clk);
        pal_we <= 1'b0;
    endtask

    task automatic set_pixels(input layer_pxl_t o, input layer_pxl_t s1,
                              input layer_pxl_t s2, input layer_pxl_t s3);
        @(posedge clk);
        obj_pxl  <= o;
        scr1_pxl <= s1;
        scr2_pxl <= s2;
        scr3_pxl <= s3;
    endtask

    // Lands once per pixel, with the state left by the previous pixel edge
    task automatic pixel_step;
        @(negedge clk);
        while (pxl_cen !== 1'b1) begin
            @(negedge clk);
        end
    endtask

    // Let the pixels pass the pipeline, then stop mid-line on a visible line
    task automatic check_screen(input string name, input pal_entry_t entry);
        repeat (pixel_latency + 1) pixel_step();
        do begin
            pixel_step();
        end while (hdump != hcount_t'(h_active / 2) || vdump >= vcount_t'(v_active));
        check_colour($sformatf("%s red", name), expected_channel(entry[11:8], entry[15:12]), red);
        check_colour($sformatf("%s green", name), expected_channel(entry[7:4], entry[15:12]),
                     green);
        check_colour($sformatf("%s blue", name), expected_channel(entry[3:0], entry[15:12]), blue);
    endtask

    task automatic check_byte_writes(input cpu_addr_t a);
        cpu_data_t exp;
        cpu_data_t val;
        cpu_data_t rd;
        val = rand_bits(16);
        exp = val;
        cpu_write(a, 2'b00, val);
        cpu_read(a, rd);
        check_cpu_data($sformatf("word write at %0d", a), exp, rd);
        val = rand_bits(16);
        exp = {val[15:8], exp[7:0]};
        cpu_write(a, 2'b01, val);
        cpu_read(a, rd);
        check_cpu_data($sformatf("high byte write at %0d", a), exp, rd);
        val = rand_bits(16);
        exp = {exp[15:8], val[7:0]};
        cpu_write(a, 2'b10, val);
        cpu_read(a, rd);
        check_cpu_data($sformatf("low byte write at %0d", a), exp, rd);
    endtask

    task automatic test_reset_readback;
        cpu_data_t rd;
        cpu_read(reg_layer_ctrl, rd);
        check_cpu_data("reset layer_ctrl", layer_ctrl_reset, rd);
        cpu_read(reg_raster, rd);
        check_cpu_data("reset raster", 16'h0000, rd);
        check_byte_writes(reg_layer_ctrl);
        check_byte_writes(reg_raster);
        cpu_read(5'd9, rd);
        check_cpu_data("unmapped read", 16'h0000, rd);
        cpu_read(5'd31, rd);
        check_cpu_data("unmapped read", 16'h0000, rd);
        cpu_write(reg_layer_ctrl, 2'b00, layer_ctrl_reset);
        cpu_write(reg_raster, 2'b00, 16'h0000);
    endtask

    task automatic test_timing;
        logic    prev_hb;
        logic    prev_hs;
        logic    prev_vb;
        logic    prev_vs;
        vcount_t hb_rises;
        vcount_t hb_run;
        vcount_t hs_run;
        vcount_t vb_lines;
        vcount_t vs_lines;
        // Start on the first pixel of a frame
        do begin
            pixel_step();
        end while (hdump != '0 || vdump != '0);
        prev_hb  = hb;
        prev_hs  = hs;
        prev_vb  = vb;
        prev_vs  = vs;
        hb_rises = '0;
        hb_run   = '0;
        hs_run   = '0;
        vb_lines = '0;
        vs_lines = '0;
        repeat (frame_pixels) begin
            pixel_step();
            if (hb && !prev_hb) begin
                check_count("hb start", vcount_t'(h_active), hdump);
                hb_rises++;
                // Vertical spans counted in lines
                if (vb) vb_lines++;
                if (vs) vs_lines++;
            end
            if (hs && !prev_hs) check_count("hs start", vcount_t'(h_sync_start), hdump);
            if (vb && !prev_vb) check_count("vb start", vcount_t'(v_active), vdump);
            if (vs && !prev_vs) check_count("vs start", vcount_t'(v_sync_start), vdump);
            if (!hb && prev_hb) begin
                check_count("hb span", vcount_t'(h_total - h_active), hb_run);
                hb_run = '0;
            end
            if (!hs && prev_hs) begin
                check_count("hs span", vcount_t'(h_sync_end - h_sync_start), hs_run);
                hs_run = '0;
            end
            if (!vb && prev_vb) check_count("vb lines", vcount_t'(v_total - v_active), vb_lines);
            if (!vs && prev_vs) check_count("vs lines", vcount_t'(v_sync_end - v_sync_start),
                                            vs_lines);
            if (hb) hb_run++;
            if (hs) hs_run++;
            prev_hb = hb;
            prev_hs = hs;
            prev_vb = vb;
            prev_vs = vs;
        end
        check_count("hb edges per frame", vcount_t'(v_total), hb_rises);
    endtask

    task automatic test_palette;
        layer_pxl_t pxl;
        pal_entry_t entry;
        for (int i = 0; i < 8; i++) begin
            pxl = layer_pxl_t'(rand_bits(9));
            if (pxl[3:0] == transparent_colour) pxl[3:0] = 4'd0;
            entry = pal_entry_t'(rand_bits(16));
            pal_write(pal_index_t'({layer_scr1, pxl}), entry);
            set_pixels(9'h00f, pxl, 9'h00f, 9'h00f);
            check_screen($sformatf("palette entry %0d", i), entry);
        end
    endtask

    // Bit n of clear_mask turns layer n transparent, exp_layer 4 is the backdrop
    task automatic run_priority(input string name, input cpu_data_t ctrl,
                                input logic [3:0] clear_mask, input int exp_layer);
        layer_pxl_t pxl [4];
        for (int id = 0; id < 4; id++) begin
            pxl[id] = clear_mask[id] ? {prio_pxl[id][8:4], transparent_colour} : prio_pxl[id];
        end
        cpu_write(reg_layer_ctrl, 2'b00, ctrl);
        set_pixels(pxl[0], pxl[1], pxl[2], pxl[3]);
        check_screen(name, layer_entry[exp_layer]);
    endtask

    task automatic test_priority;
        prio_pxl[0]    = 9'h032;
        prio_pxl[1]    = 9'h075;
        prio_pxl[2]    = 9'h0c9;
        prio_pxl[3]    = 9'h1e0;
        layer_entry[0] = 16'hfc30;
        layer_entry[1] = 16'h80c8;
        layer_entry[2] = 16'h3f0f;
        layer_entry[3] = 16'hd5a1;
        layer_entry[4] = 16'h0777;
        for (int id = 0; id < 4; id++) begin
            pal_write(pal_index_t'({id[1:0], prio_pxl[id]}), layer_entry[id]);
        end
        pal_write(backdrop_index, layer_entry[4]);
        run_priority("default order", 16'h0fe4, 4'b0000, 0);
        run_priority("obj transparent", 16'h0fe4, 4'b0001, 1);
        run_priority("bottom slot only", 16'h0fe4, 4'b0111, 3);
        run_priority("reversed order", 16'h0f1b, 4'b0000, 3);
        run_priority("scr2 disabled", 16'h0b1b, 4'b1000, 1);
        run_priority("mixed order", 16'h0e4e, 4'b0100, 3);
        run_priority("all transparent", 16'h0fe4, 4'b1111, 4);
        run_priority("all disabled", 16'h00e4, 4'b0000, 4);
        cpu_write(reg_layer_ctrl, 2'b00, layer_ctrl_reset);
    endtask

    task automatic test_blanking;
        logic [pixel_latency-1:0] hb_hist;
        logic [pixel_latency-1:0] vb_hist;
        int                       blanked;
        set_pixels({prio_pxl[0][8:4], transparent_colour}, prio_pxl[1], 9'h00f, 9'h00f);
        hb_hist = '0;
        vb_hist = '0;
        blanked = 0;
        for (int i = 0; i < frame_pixels; i++) begin
            pixel_step();
            if (i >= pixel_latency) begin
                check_level("lhbl_dly", ~hb_hist[pixel_latency-1], lhbl_dly);
                check_level("lvbl_dly", ~vb_hist[pixel_latency-1], lvbl_dly);
            end
            if (!lhbl_dly || !lvbl_dly) begin
                blanked++;
                check_colour("blank red", 8'd0, red);
                check_colour("blank green", 8'd0, green);
                check_colour("blank blue", 8'd0, blue);
            end
            hb_hist = {hb_hist[pixel_latency-2:0], hb};
            vb_hist = {vb_hist[pixel_latency-2:0], vb};
        end
        if (blanked == 0) begin
            stop_run("delayed blanking never went active during a whole frame");
        end
    endtask

    // First clock after the write still sees the old register
    task automatic count_raster(input vcount_t line, output vcount_t pulses);
        pulses = '0;
        @(posedge clk);
        repeat (frame_clks) begin
            @(negedge clk);
            if (raster) begin
                pulses++;
                check_count("raster line", line, vdump);
            end
        end
    endtask

    task automatic test_raster;
        vcount_t   line;
        vcount_t   pulses;
        cpu_data_t rd;
        line = vcount_t'(16 + rand_bits(7));
        cpu_write(reg_raster, 2'b00, {7'b1000000, line});
        count_raster(line, pulses);
        check_count("raster pulses enabled", vcount_t'(1), pulses);
        // Clear the enable through the high byte only
        cpu_write(reg_raster, 2'b01, 16'h0000);
        cpu_read(reg_raster, rd);
        check_cpu_data("raster disabled readback", {7'd0, line}, rd);
        count_raster(line, pulses);
        check_count("raster pulses disabled", vcount_t'(0), pulses);
    endtask

    initial begin
        rst        = 1'b1;
        pxl_cen    = 1'b0;
        ppu_cs     = 1'b0;
        addr       = '0;
        dsn        = 2'b11;
        cpu_dout   = '0;
        obj_pxl    = '0;
        scr1_pxl   = '0;
        scr2_pxl   = '0;
        scr3_pxl   = '0;
        pal_we     = 1'b0;
        pal_waddr  = '0;
        pal_wdata  = '0;
        lfsr_state = 32'h32d79c5a;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        test_reset_readback();
        test_timing();
        test_palette();
        test_priority();
        test_blanking();
        test_raster();
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
design/cps_video_pkg.sv
design/video_timing.sv
design/video_regs.sv
design/layer_mixer.sv
design/palette_lut.sv
design/cps_video.sv
tests/tb_cps_video.sv

/* Bender.yml */
package:
  name: cps_video

sources:
  - design/cps_video_pkg.sv
  - design/video_timing.sv
  - design/video_regs.sv
  - design/layer_mixer.sv
  - design/palette_lut.sv
  - design/cps_video.sv
  - target: test
    files:
      - tests/tb_cps_video.sv
